// ==== src.f ====
+incdir+common
common/axi_lite_pkg.sv
common/pwm_regs_pkg.sv
common/reg_access_if.sv
axi/axi_access_decode.sv
pwm_channel/pwm_channel_regs.sv
source/pwm_axi_regs.sv
verification/pwm_axi_regs_asserts.sv
verification/tb_pwm_axi_regs.sv

// ==== verification/tb_pwm_axi_regs.sv ====
`include "pwm_consts.svh"

module tb_pwm_axi_regs;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_TESTS     = 6;
   localparam int CLK_NS      = 40;
   localparam int WATCHDOG_NS = N_TESTS * 200 * CLK_NS;

   logic aclk, aresetn, arvalid, arready, rready, rvalid, awvalid, awready;
   logic wvalid, wready, bready, bvalid, pwm1, pwm2;
   logic [31:0] araddr, awaddr;
   logic [3:0]  wstrb, read_size;
   logic [`PWM_DATA_W-1:0] rdata, wdata, p1_period, p1_t1, p1_t2, p2_period, p2_t1, p2_t2;
   logic [`PWM_MODE_W-1:0] p1_mode, p2_mode;
   logic [`PWM_STEP_W-1:0] p1_step, p2_step;

   // reference model, regs indexed by channel and kind
   logic [`PWM_DATA_W-1:0] model_regs [0:1][0:4];
   logic [`PWM_DATA_W-1:0] model_rdata;
   logic [1:0]             pwm_prev; // pwm inputs one cycle back

   pwm_axi_regs pwm_axi_regs_i (
      .s_axi_aclk_i(aclk), .s_axi_aresetn_i(aresetn),
      .s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid), .s_axi_arready_o(arready),
      .s_axi_rready_i(rready), .s_axi_rvalid_o(rvalid), .s_axi_rdata_o(rdata),
      .s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready),
      .s_axi_wdata_i(wdata), .s_axi_wstrb_i(wstrb), .s_axi_wvalid_i(wvalid),
      .s_axi_wready_o(wready), .s_axi_bready_i(bready), .s_axi_bvalid_o(bvalid),
      .read_size_i(read_size),
      .pwm1_mode_o(p1_mode), .pwm1_period_o(p1_period), .pwm1_threshold1_o(p1_t1),
      .pwm1_threshold2_o(p1_t2), .pwm1_step_o(p1_step), .pwm1_i(pwm1),
      .pwm2_mode_o(p2_mode), .pwm2_period_o(p2_period), .pwm2_threshold1_o(p2_t1),
      .pwm2_threshold2_o(p2_t2), .pwm2_step_o(p2_step), .pwm2_i(pwm2)
   );

   initial begin
      aclk = 1'b0;
      forever #(CLK_NS / 2) aclk = ~aclk;
   end

   always @(posedge aclk) pwm_prev <= {pwm2, pwm1};

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "run stopped");
   endtask

   initial begin
      #(WATCHDOG_NS);
      abort_run("watchdog expired before the tests finished");
   end

   // a bound assertion failure ends the run too
   initial begin
      wait (pwm_axi_regs_i.axi_access_decode_i.pwm_axi_regs_asserts_i.fail_cnt != 0);
      abort_run("a bound assertion on the decoder failed");
   end

   task automatic next_cycle();
      @(posedge aclk);
      #2;
   endtask

   task automatic check_data(input string name, input logic [`PWM_DATA_W-1:0] got, exp);
      if (got !== exp)
         abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, exp);
      if (got !== exp)
         abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_mode(input string name, input logic [`PWM_MODE_W-1:0] got, exp);
      if (got !== exp)
         abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_step(input string name, input logic [`PWM_STEP_W-1:0] got, exp);
      if (got !== exp)
         abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_size_regs(input int ch);
      string pfx;
      pfx = $sformatf("pwm%0d", ch + 1);
      check_mode({pfx, "_mode_o"}, ch ? p2_mode : p1_mode,
                 model_regs[ch][0][`PWM_MODE_W-1:0]);
      check_data({pfx, "_period_o"}, ch ? p2_period : p1_period, model_regs[ch][1]);
      check_data({pfx, "_threshold1_o"}, ch ? p2_t1 : p1_t1, model_regs[ch][2]);
      check_data({pfx, "_threshold2_o"}, ch ? p2_t2 : p1_t2, model_regs[ch][3]);
      check_step({pfx, "_step_o"}, ch ? p2_step : p1_step,
                 model_regs[ch][4][`PWM_STEP_W-1:0]);
   endtask

   function automatic logic [31:0] make_addr(input int ch, input logic [2:0] k);
      pwm_regs_pkg::reg_offset_u off;
      off.raw = '0;
      off.f.kind = pwm_regs_pkg::reg_kind_t'(k);
      off.f.ch = ch[0];
      return `PWM_BASE_ADDR | {24'h0, off.raw};
   endfunction

   function automatic logic [3:0] size_lanes(input axi_lite_pkg::access_size_t size);
      case (size)
         axi_lite_pkg::SIZE_WORD: return 4'b1111;
         axi_lite_pkg::SIZE_HALF: return 4'b0011;
         default:                 return 4'b0001;
      endcase
   endfunction

   // offset in window, zero spare and align bits, kind up to max_kind
   function automatic logic offset_ok(input logic [31:0] addr, input int max_kind);
      pwm_regs_pkg::reg_offset_u off;
      off.raw = addr[7:0];
      return ((addr & ~(`PWM_ADDR_MASK)) == `PWM_BASE_ADDR) && off.f.spare == 2'b00
             && off.f.align == 2'b00 && int'(off.f.kind) <= max_kind;
   endfunction

   task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                            input axi_lite_pkg::access_size_t size, input logic bready_v);
      logic accept;
      int   ch;
      int   k;
      logic [31:0] old;
      accept = bready_v && offset_ok(addr, 4);
      ch = int'(addr[2]);
      k = int'(addr[5:3]);
      awaddr = addr;
      wdata = data;
      wstrb = size_lanes(size);
      awvalid = 1'b1;
      wvalid = 1'b1;
      bready = bready_v;
      next_cycle();
      awvalid = 1'b0;
      wvalid = 1'b0;
      bready = 1'b1;
      if (accept !== bvalid)
         abort_run($sformatf("write to 0x%h: bvalid was %b, response expected %b",
                             addr, bvalid, accept));
      if (accept) begin
         old = model_regs[ch][k];
         if (k == 0)
            model_regs[ch][k] = {30'h0, data[1:0]};
         else if (k == 4)
            model_regs[ch][k] = size == axi_lite_pkg::SIZE_BYTE ? {24'h0, data[7:0]}
                                                                 : {20'h0, data[11:0]};
         else if (size == axi_lite_pkg::SIZE_WORD)
            model_regs[ch][k] = data;
         else if (size == axi_lite_pkg::SIZE_HALF)
            model_regs[ch][k] = {old[31:16], data[15:0]};
         else
            model_regs[ch][k] = {old[31:8], data[7:0]};
      end
   endtask

   task automatic axi_read(input logic [31:0] addr, input axi_lite_pkg::access_size_t size,
                           input logic rready_v);
      logic accept;
      int   ch;
      int   k;
      logic [31:0] word;
      accept = rready_v && offset_ok(addr, 5);
      ch = int'(addr[2]);
      k = int'(addr[5:3]);
      word = '0;
      if (accept)
         word = k == 5 ? {31'h0, pwm_prev[ch]} : model_regs[ch][k % 5];
      araddr = addr;
      read_size = size_lanes(size);
      arvalid = 1'b1;
      rready = rready_v;
      next_cycle();
      arvalid = 1'b0;
      rready = 1'b1;
      if (accept !== rvalid)
         abort_run($sformatf("read of 0x%h: rvalid was %b, response expected %b",
                             addr, rvalid, accept));
      if (accept) begin
         if (k == 4 && size != axi_lite_pkg::SIZE_BYTE)
            model_rdata[11:0] = word[11:0]; // step is 12 bits wide
         else if (size == axi_lite_pkg::SIZE_WORD)
            model_rdata = word;
         else if (size == axi_lite_pkg::SIZE_HALF)
            model_rdata[15:0] = word[15:0];
         else
            model_rdata[7:0] = word[7:0];
      end
      check_data("s_axi_rdata_o", rdata, model_rdata);
   endtask

   task automatic test_reset_values();
      repeat (16) next_cycle();
      check_flag("s_axi_rvalid_o", rvalid, 1'b0);
      check_flag("s_axi_bvalid_o", bvalid, 1'b0);
      check_flag("s_axi_arready_o", arready, 1'b0);
      check_data("s_axi_rdata_o", rdata, '0);
      aresetn = 1'b1;
      next_cycle();
      check_flag("s_axi_arready_o", arready, 1'b1);
      check_flag("s_axi_awready_o", awready, 1'b1);
      check_flag("s_axi_wready_o", wready, 1'b1);
      for (int ch = 0; ch < 2; ch++) begin
         check_size_regs(ch);
         for (int k = 0; k < 6; k++)
            axi_read(make_addr(ch, k), axi_lite_pkg::SIZE_WORD, 1'b1);
      end
   endtask

   task automatic test_word_writes();
      for (int ch = 0; ch < 2; ch++) begin
         for (int k = 0; k < 5; k++) begin
            axi_write(make_addr(ch, k), $urandom, axi_lite_pkg::SIZE_WORD, 1'b1);
            check_size_regs(ch);
         end
         for (int k = 0; k < 5; k++)
            axi_read(make_addr(ch, k), axi_lite_pkg::SIZE_WORD, 1'b1);
      end
   endtask

   task automatic test_narrow_writes();
      for (int ch = 0; ch < 2; ch++)
         for (int k = 0; k < 5; k++) begin
            axi_write(make_addr(ch, k), $urandom, axi_lite_pkg::SIZE_HALF, 1'b1);
            check_size_regs(ch);
            axi_write(make_addr(ch, k), $urandom, axi_lite_pkg::SIZE_BYTE, 1'b1);
            check_size_regs(ch);
            axi_read(make_addr(ch, k), axi_lite_pkg::SIZE_WORD, 1'b1);
         end
   endtask

   // mix registers so the narrow lanes differ from the held word
   task automatic test_narrow_reads();
      for (int ch = 0; ch < 2; ch++)
         for (int k = 0; k < 5; k++) begin
            axi_read(make_addr(ch, k), axi_lite_pkg::SIZE_WORD, 1'b1);
            axi_read(make_addr(ch, (k + 1) % 5), axi_lite_pkg::SIZE_HALF, 1'b1);
            axi_read(make_addr(ch, (k + 2) % 5), axi_lite_pkg::SIZE_BYTE, 1'b1);
         end
   endtask

   task automatic test_status_and_drops();
      for (int ch = 0; ch < 2; ch++) begin
         if (ch == 0) pwm1 = 1'b1;
         else         pwm2 = 1'b1;
         next_cycle();
         if (ch == 0) pwm1 = 1'b0; // read still sees the old level
         else         pwm2 = 1'b0;
         axi_read(make_addr(ch, 5), axi_lite_pkg::SIZE_WORD, 1'b1);
         axi_read(make_addr(ch, 5), axi_lite_pkg::SIZE_WORD, 1'b1);
         axi_write(make_addr(ch, 5), $urandom, axi_lite_pkg::SIZE_WORD, 1'b1);
         axi_write(make_addr(ch, 6), $urandom, axi_lite_pkg::SIZE_WORD, 1'b1);
         axi_write(make_addr(ch, 7), $urandom, axi_lite_pkg::SIZE_WORD, 1'b1);
         axi_write(make_addr(ch, 1) + 32'h100, $urandom, axi_lite_pkg::SIZE_WORD, 1'b1);
         axi_write(make_addr(ch, 2) + 32'h2, $urandom, axi_lite_pkg::SIZE_WORD, 1'b1);
         axi_write(make_addr(ch, 3) | 32'h40, $urandom, axi_lite_pkg::SIZE_WORD, 1'b1);
         axi_read(make_addr(ch, 6), axi_lite_pkg::SIZE_WORD, 1'b1);
         axi_read(make_addr(ch, 1) ^ 32'h0100_0000, axi_lite_pkg::SIZE_WORD, 1'b1);
         check_size_regs(ch);
      end
   endtask

   task automatic test_no_ready();
      for (int ch = 0; ch < 2; ch++) begin
         axi_write(make_addr(ch, 1), $urandom, axi_lite_pkg::SIZE_WORD, 1'b0);
         axi_read(make_addr(ch, 2), axi_lite_pkg::SIZE_WORD, 1'b0);
         check_size_regs(ch);
      end
   endtask

   initial begin
      void'($urandom(65));
      aresetn = 1'b0;
      {araddr, arvalid, awaddr, awvalid, wdata, wstrb, wvalid, read_size} = '0;
      {rready, bready, pwm1, pwm2} = 4'b1100;
      model_regs = '{default: '0};
      model_rdata = '0;
      test_reset_values();
      test_word_writes();
      test_narrow_writes();
      test_narrow_reads();
      test_status_and_drops();
      test_no_ready();
      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== verification/pwm_axi_regs_asserts.sv ====
`include "pwm_consts.svh"

module pwm_axi_regs_asserts (
   input logic        clk_i,
   input logic        rstn_i,
   input logic [31:0] araddr_i,
   input logic        arvalid_i,
   input logic        rready_i,
   input logic        arready_i,
   input logic        awready_i,
   input logic        wready_i,
   input logic        rvalid_i,
   input logic        bvalid_i
);
   timeunit 1ns;
   timeprecision 100ps;

   logic        rd_accept;
   int unsigned fail_cnt = 0; // failed assertions so far

   // in window, aligned, kind 0 to 5
   assign rd_accept = arvalid_i && rready_i
                      && ((araddr_i & ~(`PWM_ADDR_MASK)) == `PWM_BASE_ADDR)
                      && araddr_i[7:6] == 2'b00 && araddr_i[1:0] == 2'b00
                      && araddr_i[5:3] <= 3'd5;

   a_quiet_in_reset: assert property (@(posedge clk_i) !rstn_i |=> !rvalid_i && !bvalid_i)
      else begin
         fail_cnt++;
         $error("response valid while reset is asserted");
      end

   a_ready_after_reset: assert property (@(posedge clk_i)
      rstn_i |=> arready_i && awready_i && wready_i)
      else begin
         fail_cnt++;
         $error("ready outputs not high after reset release");
      end

   a_rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rstn_i)
      rvalid_i |-> $past(rd_accept))
      else begin
         fail_cnt++;
         $error("rvalid without an accepted read");
      end

endmodule

bind axi_access_decode pwm_axi_regs_asserts pwm_axi_regs_asserts_i (
   .clk_i     (s_axi_aclk_i),
   .rstn_i    (s_axi_aresetn_i),
   .araddr_i  (s_axi_araddr_i),
   .arvalid_i (s_axi_arvalid_i),
   .rready_i  (s_axi_rready_i),
   .arready_i (s_axi_arready_o),
   .awready_i (s_axi_awready_o),
   .wready_i  (s_axi_wready_o),
   .rvalid_i  (s_axi_rvalid_o),
   .bvalid_i  (s_axi_bvalid_o)
);

// ==== source/pwm_axi_regs.sv ====
`include "pwm_consts.svh"

module pwm_axi_regs (
   input  logic                   s_axi_aclk_i,
   input  logic                   s_axi_aresetn_i,

   input  logic [31:0]            s_axi_araddr_i,
   input  logic                   s_axi_arvalid_i,
   output logic                   s_axi_arready_o,

   input  logic                   s_axi_rready_i,
   output logic                   s_axi_rvalid_o,
   output logic [`PWM_DATA_W-1:0] s_axi_rdata_o,

   input  logic [31:0]            s_axi_awaddr_i,
   input  logic                   s_axi_awvalid_i,
   output logic                   s_axi_awready_o,

   input  logic [`PWM_DATA_W-1:0] s_axi_wdata_i,
   input  logic [3:0]             s_axi_wstrb_i,
   input  logic                   s_axi_wvalid_i,
   output logic                   s_axi_wready_o,

   input  logic                   s_axi_bready_i,
   output logic                   s_axi_bvalid_o,

   input  logic [3:0]             read_size_i,

   output logic [`PWM_MODE_W-1:0] pwm1_mode_o,
   output logic [`PWM_DATA_W-1:0] pwm1_period_o,
   output logic [`PWM_DATA_W-1:0] pwm1_threshold1_o,
   output logic [`PWM_DATA_W-1:0] pwm1_threshold2_o,
   output logic [`PWM_STEP_W-1:0] pwm1_step_o,
   input  logic                   pwm1_i,

   output logic [`PWM_MODE_W-1:0] pwm2_mode_o,
   output logic [`PWM_DATA_W-1:0] pwm2_period_o,
   output logic [`PWM_DATA_W-1:0] pwm2_threshold1_o,
   output logic [`PWM_DATA_W-1:0] pwm2_threshold2_o,
   output logic [`PWM_STEP_W-1:0] pwm2_step_o,
   input  logic                   pwm2_i
);

   reg_access_if ch0_if ();
   reg_access_if ch1_if ();

   axi_access_decode axi_access_decode_i (
      .s_axi_aclk_i    (s_axi_aclk_i),
      .s_axi_aresetn_i (s_axi_aresetn_i),
      .s_axi_araddr_i  (s_axi_araddr_i),
      .s_axi_arvalid_i (s_axi_arvalid_i),
      .s_axi_arready_o (s_axi_arready_o),
      .s_axi_rready_i  (s_axi_rready_i),
      .s_axi_rvalid_o  (s_axi_rvalid_o),
      .s_axi_rdata_o   (s_axi_rdata_o),
      .s_axi_awaddr_i  (s_axi_awaddr_i),
      .s_axi_awvalid_i (s_axi_awvalid_i),
      .s_axi_awready_o (s_axi_awready_o),
      .s_axi_wdata_i   (s_axi_wdata_i),
      .s_axi_wstrb_i   (s_axi_wstrb_i),
      .s_axi_wvalid_i  (s_axi_wvalid_i),
      .s_axi_wready_o  (s_axi_wready_o),
      .s_axi_bready_i  (s_axi_bready_i),
      .s_axi_bvalid_o  (s_axi_bvalid_o),
      .read_size_i     (read_size_i),
      .ch0             (ch0_if.decoder),
      .ch1             (ch1_if.decoder)
   );

   // channel 0 is pwm1, offset bit 2 clear
   pwm_channel_regs pwm_channel_regs_0_i (
      .s_axi_aclk_i    (s_axi_aclk_i),
      .s_axi_aresetn_i (s_axi_aresetn_i),
      .pwm_i           (pwm1_i),
      .acc             (ch0_if.bank),
      .mode_o          (pwm1_mode_o),
      .period_o        (pwm1_period_o),
      .threshold1_o    (pwm1_threshold1_o),
      .threshold2_o    (pwm1_threshold2_o),
      .step_o          (pwm1_step_o)
   );

   pwm_channel_regs pwm_channel_regs_1_i (
      .s_axi_aclk_i    (s_axi_aclk_i),
      .s_axi_aresetn_i (s_axi_aresetn_i),
      .pwm_i           (pwm2_i),
      .acc             (ch1_if.bank),
      .mode_o          (pwm2_mode_o),
      .period_o        (pwm2_period_o),
      .threshold1_o    (pwm2_threshold1_o),
      .threshold2_o    (pwm2_threshold2_o),
      .step_o          (pwm2_step_o)
   );

endmodule

// ==== pwm_channel/pwm_channel_regs.sv ====
`include "pwm_consts.svh"

module pwm_channel_regs (
   input  logic                   s_axi_aclk_i,
   input  logic                   s_axi_aresetn_i,
   input  logic                   pwm_i,

   reg_access_if.bank             acc,

   output logic [`PWM_MODE_W-1:0] mode_o,
   output logic [`PWM_DATA_W-1:0] period_o,
   output logic [`PWM_DATA_W-1:0] threshold1_o,
   output logic [`PWM_DATA_W-1:0] threshold2_o,
   output logic [`PWM_STEP_W-1:0] step_o
);

   logic [`PWM_MODE_W-1:0] mode_q;
   logic [`PWM_DATA_W-1:0] period_q;
   logic [`PWM_DATA_W-1:0] thresh1_q;
   logic [`PWM_DATA_W-1:0] thresh2_q;
   logic [`PWM_STEP_W-1:0] step_q;
   logic                   status_q;

   // word replaces all, half the low 16 bits, byte the low 8
   function automatic logic [`PWM_DATA_W-1:0] merge_lanes(
      input logic [`PWM_DATA_W-1:0] old_val,
      input logic [`PWM_DATA_W-1:0] new_val,
      input axi_lite_pkg::access_size_t size
   );
      logic [`PWM_DATA_W-1:0] res;
      res = old_val;
      case (size)
         axi_lite_pkg::SIZE_WORD: res = new_val;
         axi_lite_pkg::SIZE_HALF: res[15:0] = new_val[15:0];
         default:                 res[7:0] = new_val[7:0];
      endcase
      return res;
   endfunction

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         mode_q    <= '0;
         period_q  <= '0;
         thresh1_q <= '0;
         thresh2_q <= '0;
         step_q    <= '0;
         status_q  <= 1'b0;
      end else begin
         status_q <= pwm_i; // sampled every cycle
         if (acc.wr_stb) begin
            case (acc.kind)
               pwm_regs_pkg::KIND_MODE:    mode_q <= acc.wdata[`PWM_MODE_W-1:0];
               pwm_regs_pkg::KIND_PERIOD:
                  period_q <= merge_lanes(period_q, acc.wdata, acc.wr_size);
               pwm_regs_pkg::KIND_THRESH1:
                  thresh1_q <= merge_lanes(thresh1_q, acc.wdata, acc.wr_size);
               pwm_regs_pkg::KIND_THRESH2:
                  thresh2_q <= merge_lanes(thresh2_q, acc.wdata, acc.wr_size);
               pwm_regs_pkg::KIND_STEP: begin
                  if (acc.wr_size == axi_lite_pkg::SIZE_BYTE)
                     step_q <= {4'h0, acc.wdata[7:0]}; // byte clears upper nibble
                  else
                     step_q <= acc.wdata[`PWM_STEP_W-1:0];
               end
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (acc.rd_kind)
         pwm_regs_pkg::KIND_MODE:    acc.rd_word = `PWM_DATA_W'(mode_q);
         pwm_regs_pkg::KIND_PERIOD:  acc.rd_word = period_q;
         pwm_regs_pkg::KIND_THRESH1: acc.rd_word = thresh1_q;
         pwm_regs_pkg::KIND_THRESH2: acc.rd_word = thresh2_q;
         pwm_regs_pkg::KIND_STEP:    acc.rd_word = `PWM_DATA_W'(step_q);
         pwm_regs_pkg::KIND_STATUS:  acc.rd_word = `PWM_DATA_W'(status_q);
         default:                    acc.rd_word = '0;
      endcase
   end

   assign mode_o       = mode_q;
   assign period_o     = period_q;
   assign threshold1_o = thresh1_q;
   assign threshold2_o = thresh2_q;
   assign step_o       = step_q;

endmodule

// ==== axi/axi_access_decode.sv ====
`include "pwm_consts.svh"

module axi_access_decode (
   input  logic                   s_axi_aclk_i,
   input  logic                   s_axi_aresetn_i,

   input  logic [31:0]            s_axi_araddr_i,
   input  logic                   s_axi_arvalid_i,
   output logic                   s_axi_arready_o,

   input  logic                   s_axi_rready_i,
   output logic                   s_axi_rvalid_o,
   output logic [`PWM_DATA_W-1:0] s_axi_rdata_o,

   input  logic [31:0]            s_axi_awaddr_i,
   input  logic                   s_axi_awvalid_i,
   output logic                   s_axi_awready_o,

   input  logic [`PWM_DATA_W-1:0] s_axi_wdata_i,
   input  logic [3:0]             s_axi_wstrb_i,
   input  logic                   s_axi_wvalid_i,
   output logic                   s_axi_wready_o,

   input  logic                   s_axi_bready_i,
   output logic                   s_axi_bvalid_o,

   input  logic [3:0]             read_size_i,

   reg_access_if.decoder          ch0,
   reg_access_if.decoder          ch1
);

   pwm_regs_pkg::reg_offset_u  rd_off;
   pwm_regs_pkg::reg_offset_u  wr_off;
   axi_lite_pkg::access_size_t rd_size;
   axi_lite_pkg::access_size_t wr_size;

   logic                   rd_in_win;
   logic                   wr_in_win;
   logic                   rd_ok;
   logic                   wr_ok;
   logic [`PWM_DATA_W-1:0] rd_word_sel;
   logic [`PWM_DATA_W-1:0] rdata_next;

   logic                   ready_q;
   logic                   rvalid_q;
   logic                   bvalid_q;
   logic [`PWM_DATA_W-1:0] rdata_q;

   assign rd_off = s_axi_araddr_i[`PWM_OFFSET_W-1:0];
   assign wr_off = s_axi_awaddr_i[`PWM_OFFSET_W-1:0];

   assign rd_in_win = (s_axi_araddr_i & ~`PWM_ADDR_MASK) == `PWM_BASE_ADDR;
   assign wr_in_win = (s_axi_awaddr_i & ~`PWM_ADDR_MASK) == `PWM_BASE_ADDR;

   assign rd_size = axi_lite_pkg::size_from_lanes(read_size_i);
   assign wr_size = axi_lite_pkg::size_from_lanes(s_axi_wstrb_i);

   // served only when the response side is already ready
   assign rd_ok = s_axi_arvalid_i && s_axi_rready_i && rd_in_win
                  && rd_off.f.spare == 2'b00 && rd_off.f.align == 2'b00
                  && rd_off.f.kind <= pwm_regs_pkg::KIND_STATUS;

   assign wr_ok = s_axi_awvalid_i && s_axi_wvalid_i && s_axi_bready_i && wr_in_win
                  && wr_off.f.spare == 2'b00 && wr_off.f.align == 2'b00
                  && wr_off.f.kind < pwm_regs_pkg::KIND_STATUS; // status is read only

   assign ch0.wr_stb  = wr_ok && !wr_off.f.ch;
   assign ch0.kind    = wr_off.f.kind;
   assign ch0.rd_kind = rd_off.f.kind;
   assign ch0.wr_size = wr_size;
   assign ch0.wdata   = s_axi_wdata_i;

   assign ch1.wr_stb  = wr_ok && wr_off.f.ch;
   assign ch1.kind    = wr_off.f.kind;
   assign ch1.rd_kind = rd_off.f.kind;
   assign ch1.wr_size = wr_size;
   assign ch1.wdata   = s_axi_wdata_i;

   assign rd_word_sel = rd_off.f.ch ? ch1.rd_word : ch0.rd_word;

   // merge read lanes into the held data
   always_comb begin
      rdata_next = rdata_q;
      if (rd_off.f.kind == pwm_regs_pkg::KIND_STEP) begin
         if (rd_size == axi_lite_pkg::SIZE_BYTE)
            rdata_next[7:0] = rd_word_sel[7:0];
         else
            rdata_next[`PWM_STEP_W-1:0] = rd_word_sel[`PWM_STEP_W-1:0];
      end else begin
         case (rd_size)
            axi_lite_pkg::SIZE_WORD: rdata_next = rd_word_sel;
            axi_lite_pkg::SIZE_HALF: rdata_next[15:0] = rd_word_sel[15:0];
            default:                 rdata_next[7:0] = rd_word_sel[7:0];
         endcase
      end
   end

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         ready_q  <= 1'b0;
         rvalid_q <= 1'b0;
         bvalid_q <= 1'b0;
         rdata_q  <= '0;
      end else begin
         ready_q  <= 1'b1; // stays high from here on
         rvalid_q <= rd_ok;
         bvalid_q <= wr_ok;
         if (rd_ok)
            rdata_q <= rdata_next;
      end
   end

   assign s_axi_arready_o = ready_q;
   assign s_axi_awready_o = ready_q;
   assign s_axi_wready_o  = ready_q;
   assign s_axi_rvalid_o  = rvalid_q;
   assign s_axi_bvalid_o  = bvalid_q;
   assign s_axi_rdata_o   = rdata_q;

endmodule

// ==== common/reg_access_if.sv ====
`include "pwm_consts.svh"

interface reg_access_if;

   logic                      wr_stb;
   pwm_regs_pkg::reg_kind_t   kind;    // write side
   pwm_regs_pkg::reg_kind_t   rd_kind;
   axi_lite_pkg::access_size_t wr_size;
   logic [`PWM_DATA_W-1:0]    wdata;
   logic [`PWM_DATA_W-1:0]    rd_word;

   modport decoder (
      output wr_stb,
      output kind,
      output rd_kind,
      output wr_size,
      output wdata,
      input  rd_word
   );

   modport bank (
      input  wr_stb,
      input  kind,
      input  rd_kind,
      input  wr_size,
      input  wdata,
      output rd_word
   );

endinterface

// ==== common/pwm_regs_pkg.sv ====
`include "pwm_consts.svh"

package pwm_regs_pkg;

   typedef enum logic [2:0] {
      KIND_MODE    = 3'd0,
      KIND_PERIOD  = 3'd1,
      KIND_THRESH1 = 3'd2,
      KIND_THRESH2 = 3'd3,
      KIND_STEP    = 3'd4,
      KIND_STATUS  = 3'd5
   } reg_kind_t; // 6 and 7 unmapped

   typedef struct packed {
      logic [1:0] spare; // must be zero
      reg_kind_t  kind;
      logic       ch;
      logic [1:0] align; // must be zero
   } reg_offset_t;

   // same offset byte, raw or split into fields
   typedef union packed {
      logic [`PWM_OFFSET_W-1:0] raw;
      reg_offset_t              f;
   } reg_offset_u;

endpackage

// ==== common/axi_lite_pkg.sv ====
package axi_lite_pkg;

   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } access_size_t;

   // lane 3 means word, lane 1 half, anything else a byte
   function automatic access_size_t size_from_lanes(input logic [3:0] lanes);
      access_size_t size;
      if (lanes[3])
         size = SIZE_WORD;
      else if (lanes[1])
         size = SIZE_HALF;
      else
         size = SIZE_BYTE;
      return size;
   endfunction

endpackage

// ==== common/pwm_consts.svh ====
`ifndef PWM_CONSTS_SVH
`define PWM_CONSTS_SVH

// register window
`define PWM_BASE_ADDR 32'h2002_0000
`define PWM_ADDR_MASK 32'h0000_00ff

// widths
`define PWM_DATA_W    32
`define PWM_MODE_W    2
`define PWM_STEP_W    12
`define PWM_OFFSET_W  8

`endif
